/* filelist.f */
rtl/rx_fifo_pkg.sv
rtl/fifo_wr_if.sv
rtl/frame_write_fsm.sv
rtl/frame_pointers.sv
rtl/frame_buffer.sv
rtl/rx_frame_fifo.sv
test/clk_gen.sv
test/rx_frame_fifo_chk.sv
test/tb_rx_frame_fifo.sv

/* Makefile */
SIM      := verilator
TOP      := tb_rx_frame_fifo
FILELIST := filelist.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert
SIM_ARGS := +verilator+error+limit+100
PASS_MSG := Simulation finished: PASS

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_rx_frame_fifo.sv */
`timescale 1ns/100ps

module tb_rx_frame_fifo
    import rx_fifo_pkg::*;
();

    localparam int ADDR_W          = 4;
    localparam int DEPTH           = 1 << ADDR_W;
    localparam int NUM_FRAMES      = 48;
    localparam int MAX_BEATS       = NUM_FRAMES * 8 + 45;
    localparam int WATCHDOG_CYCLES = MAX_BEATS * 4 + 200;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // Status vector order is {overflow, bad_frame, good_frame}
    localparam logic [2:0] KIND_GOOD = 3'b001;
    localparam logic [2:0] KIND_BAD  = 3'b010;
    localparam logic [2:0] KIND_OVF  = 3'b100;

    logic        logic_clk;
    logic        logic_rst;
    logic        in_valid;
    logic        in_last;
    logic        in_user;
    beat_data_t  in_data;
    beat_keep_t  in_keep;
    logic        out_valid;
    logic        out_ready;
    logic        out_last;
    beat_data_t  out_data;
    beat_keep_t  out_keep;
    logic        overflow;
    logic        bad_frame;
    logic        good_frame;

    logic [31:0] lfsr       = 32'd58;
    logic        hold_ready = 1'b0;
    logic        status_due = 1'b0;
    beat_data_t  exp_data[$];
    beat_keep_t  exp_keep[$];
    logic        exp_last[$];
    logic [2:0]  exp_kind[$];

    clk_gen u_clk (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst)
    );

    rx_frame_fifo #(.ADDR_W(ADDR_W)) u_dut (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic int random_len();
        logic [63:0] bits;
        bits = take_bits(3);
        return int'(bits[2:0]) + 1;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    // Advance to the next rising edge and pick a random out_ready unless stalled
    task automatic tick();
        logic [63:0] bits;
        @(posedge logic_clk);
        if (hold_ready) begin
            out_ready <= 1'b0;
        end else begin
            bits = take_bits(1);
            out_ready <= bits[0];
        end
    endtask

    task automatic drive_idle();
        tick();
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        in_user  <= 1'b0;
    endtask

    task automatic drain();
        hold_ready = 1'b0;
        drive_idle();
        while (exp_data.size() != 0) begin
            drive_idle();
        end
    endtask

    task automatic send_frame(input int nbeats, input logic [2:0] kind);
        logic [63:0] bits;
        beat_data_t  data;
        beat_keep_t  keep;
        // Frames meant to be stored wait until they are sure to fit
        if (kind != KIND_OVF) begin
            while (exp_data.size() + nbeats > DEPTH) begin
                drive_idle();
            end
        end
        exp_kind.push_back(kind);
        for (int i = 0; i < nbeats; i++) begin
            bits = take_bits(2);
            while (bits[1:0] == 2'b00) begin
                drive_idle();
                bits = take_bits(2);
            end
            data = take_bits(DATA_W);
            keep = '1;
            if (i == nbeats - 1) begin
                bits = take_bits(3);
                keep = keep >> (3'd7 - bits[2:0]);
            end
            tick();
            in_valid <= 1'b1;
            in_data  <= data;
            in_keep  <= keep;
            in_last  <= (i == nbeats - 1);
            in_user  <= (i == nbeats - 1) && (kind == KIND_BAD);
            if (kind == KIND_GOOD) begin
                exp_data.push_back(data);
                exp_keep.push_back(keep);
                exp_last.push_back(i == nbeats - 1);
            end
        end
    endtask

    // Compare in mid-cycle once all DUT signals have settled
    always @(negedge logic_clk) begin
        logic [2:0] kind;
        if (u_dut.u_chk.fail_count != 0) begin
            abort_run("A bound checker assertion failed, see the error above");
        end
        if (!logic_rst && status_due) begin
            kind = exp_kind.pop_front();
            assert ({overflow, bad_frame, good_frame} == kind)
            else abort_run($sformatf("[FAIL] %0t: status %b, expected %b", $time,
                                     {overflow, bad_frame, good_frame}, kind));
        end
        if (!logic_rst && out_valid && out_ready) begin
            assert (exp_data.size() != 0)
            else abort_run($sformatf("[FAIL] %0t: output beat with no frame pending", $time));
            assert (out_data == exp_data[0] && out_keep == exp_keep[0] &&
                    out_last == exp_last[0])
            else abort_run($sformatf("[FAIL] %0t: got %h/%h/%b, expected %h/%h/%b", $time,
                                     out_data, out_keep, out_last,
                                     exp_data[0], exp_keep[0], exp_last[0]));
            void'(exp_data.pop_front());
            void'(exp_keep.pop_front());
            void'(exp_last.pop_front());
        end
        status_due = !logic_rst && in_valid && in_last;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge logic_clk);
        abort_run($sformatf("Timeout after %0d cycles, frames stopped moving", WATCHDOG_CYCLES));
    end

    initial begin
        in_valid  = 1'b0;
        in_data   = '0;
        in_keep   = '0;
        in_last   = 1'b0;
        in_user   = 1'b0;
        out_ready = 1'b0;
        @(negedge logic_rst);
        // Mostly good frames with every sixth one marked bad
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(random_len(), (f % 6 == 5) ? KIND_BAD : KIND_GOOD);
        end
        drain();
        // Stalled output fills storage and the next frame is dropped
        hold_ready = 1'b1;
        send_frame(8, KIND_GOOD);
        send_frame(5, KIND_GOOD);
        send_frame(3, KIND_GOOD);
        send_frame(4, KIND_OVF);
        drain();
        // Frame longer than storage never fits
        hold_ready = 1'b1;
        send_frame(DEPTH + 1, KIND_OVF);
        send_frame(random_len(), KIND_GOOD);
        drain();
        repeat (4) drive_idle();
        // Assertion actions from the final rising edge are visible by the falling edge
        @(negedge logic_clk);
        if (u_dut.u_chk.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("Run ended with a bound checker assertion failure");
        end
    end

endmodule

/* test/rx_frame_fifo_chk.sv */
`timescale 1ns/100ps

module rx_frame_fifo_chk
    import rx_fifo_pkg::*;
(
    input logic       logic_clk,
    input logic       logic_rst,
    input logic       in_valid,
    input logic       in_last,
    input logic       out_valid,
    input logic       out_ready,
    input beat_data_t out_data,
    input beat_keep_t out_keep,
    input logic       out_last,
    input logic       overflow,
    input logic       bad_frame,
    input logic       good_frame
);

    // Failed properties, one counter each
    int unsigned status_errs = 0;
    int unsigned stray_errs  = 0;
    int unsigned hold_errs   = 0;
    int unsigned reset_errs  = 0;
    int unsigned fail_count;
    logic [2:0]  status;

    assign fail_count = status_errs + stray_errs + hold_errs + reset_errs;
    assign status     = {overflow, bad_frame, good_frame};

    // Every frame end gives exactly one status pulse
    one_status_per_frame: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (in_valid && in_last) |=> $onehot(status)
    ) else begin
        status_errs++;
        $error("no single status pulse after a last input beat");
    end

    no_stray_status: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        !(in_valid && in_last) |=> (status == 3'b000)
    ) else begin
        stray_errs++;
        $error("status pulse without a preceding last input beat");
    end

    // Output beat is frozen while stalled
    hold_under_stall: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) &&
                                       $stable(out_keep) && $stable(out_last))
    ) else begin
        hold_errs++;
        $error("output beat changed while out_ready was low");
    end

    quiet_in_reset: assert property (
        @(posedge logic_clk)
        logic_rst |=> (!out_valid && status == 3'b000)
    ) else begin
        reset_errs++;
        $error("out_valid or a status output high during or right after reset");
    end

endmodule

bind rx_frame_fifo rx_frame_fifo_chk u_chk (
    .logic_clk  (logic_clk),
    .logic_rst  (logic_rst),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_keep   (out_keep),
    .out_last   (out_last),
    .overflow   (overflow),
    .bad_frame  (bad_frame),
    .good_frame (good_frame)
);

/* test/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 2
) (
    output logic logic_clk,
    output logic logic_rst
);

    initial begin
        logic_clk = 1'b0;
        forever #(HALF_PERIOD) logic_clk = ~logic_clk;
    end

    // Reset drops on a rising edge, same as the other driven inputs
    initial begin
        logic_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge logic_clk);
        logic_rst <= 1'b0;
    end

endmodule

/* rtl/rx_frame_fifo.sv */
`timescale 1ns/100ps

module rx_frame_fifo
    import rx_fifo_pkg::*;
#(
    parameter int ADDR_W = 4
) (
    input  logic       logic_clk,
    input  logic       logic_rst,

    // MAC side, no back-pressure
    input  logic       in_valid,
    input  beat_data_t in_data,
    input  beat_keep_t in_keep,
    input  logic       in_last,
    input  logic       in_user,

    // Frame stream out
    output logic       out_valid,
    input  logic       out_ready,
    output beat_data_t out_data,
    output beat_keep_t out_keep,
    output logic       out_last,

    // One pulse per input frame
    output logic       overflow,
    output logic       bad_frame,
    output logic       good_frame
);

    logic [ADDR_W-1:0] rd_addr;
    logic              avail;
    logic              rd_take;

    fifo_wr_if #(.ADDR_W(ADDR_W)) wr_bus ();

    frame_write_fsm u_wr_fsm (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_keep    (in_keep),
        .in_last    (in_last),
        .in_user    (in_user),
        .wr         (wr_bus.fsm),
        .overflow   (overflow),
        .bad_frame  (bad_frame),
        .good_frame (good_frame)
    );

    frame_pointers #(.ADDR_W(ADDR_W)) u_ptrs (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .wr        (wr_bus.ptr),
        .rd_take   (rd_take),
        .rd_addr   (rd_addr),
        .avail     (avail)
    );

    frame_buffer #(.ADDR_W(ADDR_W)) u_buf (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .wr        (wr_bus.buff),
        .rd_addr   (rd_addr),
        .avail     (avail),
        .rd_take   (rd_take),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last)
    );

endmodule

/* rtl/frame_buffer.sv */
`timescale 1ns/100ps

module frame_buffer
    import rx_fifo_pkg::*;
#(
    parameter int ADDR_W = 4
) (
    input  logic              logic_clk,
    input  logic              logic_rst,

    fifo_wr_if.buff           wr,

    input  logic [ADDR_W-1:0] rd_addr,
    input  logic              avail,
    output logic              rd_take,

    output logic              out_valid,
    input  logic              out_ready,
    output beat_data_t        out_data,
    output beat_keep_t        out_keep,
    output logic              out_last
);

    localparam int DEPTH = 1 << ADDR_W;

    beat_data_t mem_data [DEPTH];
    beat_keep_t mem_keep [DEPTH];
    logic       mem_last [DEPTH];

    // Beat storage
    always_ff @(posedge logic_clk) begin
        if (wr.wr_en) begin
            mem_data[wr.wr_addr] <= wr.wr_data;
            mem_keep[wr.wr_addr] <= wr.wr_keep;
            mem_last[wr.wr_addr] <= wr.wr_last;
        end
    end

    // Refill the output register when empty or draining this cycle
    assign rd_take = avail && (!out_valid || out_ready);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            out_valid <= 1'b0;
        end else if (rd_take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload only moves on a load, so it holds under stall
    always_ff @(posedge logic_clk) begin
        if (rd_take) begin
            out_data <= mem_data[rd_addr];
            out_keep <= mem_keep[rd_addr];
            out_last <= mem_last[rd_addr];
        end
    end

endmodule

/* rtl/frame_pointers.sv */
`timescale 1ns/100ps

module frame_pointers #(
    parameter int ADDR_W = 4
) (
    input  logic              logic_clk,
    input  logic              logic_rst,

    fifo_wr_if.ptr            wr,

    input  logic              rd_take,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              avail
);

    // One extra wrap bit to tell full from empty
    typedef logic [ADDR_W:0] ptr_t;

    ptr_t wr_ptr;
    ptr_t cm_ptr;
    ptr_t rd_ptr;
    ptr_t wr_ptr_inc;
    logic full;

    assign wr_ptr_inc = wr_ptr + ptr_t'(1);

    // Write side pointer, pulled back to the last commit on rollback
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr <= '0;
        end else if (wr.rollback) begin
            wr_ptr <= cm_ptr;
        end else if (wr.wr_en) begin
            wr_ptr <= wr_ptr_inc;
        end
    end

    // Committed pointer includes the last beat written with the commit
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            cm_ptr <= '0;
        end else if (wr.commit) begin
            cm_ptr <= wr.wr_en ? wr_ptr_inc : wr_ptr;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr <= '0;
        end else if (rd_take) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
        end
    end

    // Full when wrap bits differ and addresses match
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign wr.room    = !full;
    assign wr.wr_addr = wr_ptr[ADDR_W-1:0];

    // Only committed beats are visible to the reader
    assign avail   = (cm_ptr != rd_ptr);
    assign rd_addr = rd_ptr[ADDR_W-1:0];

endmodule

/* rtl/frame_write_fsm.sv */
`timescale 1ns/100ps

module frame_write_fsm
    import rx_fifo_pkg::*;
(
    input  logic       logic_clk,
    input  logic       logic_rst,

    input  logic       in_valid,
    input  beat_data_t in_data,
    input  beat_keep_t in_keep,
    input  logic       in_last,
    input  logic       in_user,

    fifo_wr_if.fsm     wr,

    output logic       overflow,
    output logic       bad_frame,
    output logic       good_frame
);

    wr_state_t state;
    wr_state_t state_next;
    logic      overflow_next;
    logic      bad_next;
    logic      good_next;

    // Payload goes straight to storage; only the strobe is qualified
    assign wr.wr_data = in_data;
    assign wr.wr_keep = in_keep;
    assign wr.wr_last = in_last;

    always_comb begin
        state_next    = state;
        wr.wr_en      = 1'b0;
        wr.commit     = 1'b0;
        wr.rollback   = 1'b0;
        overflow_next = 1'b0;
        bad_next      = 1'b0;
        good_next     = 1'b0;

        if (in_valid) begin
            case (state)
                WR_IDLE, WR_STORE: begin
                    if (!wr.room) begin
                        // Out of space, discard what this frame has written so far
                        wr.rollback = 1'b1;
                        if (in_last) begin
                            overflow_next = 1'b1;
                            state_next    = WR_IDLE;
                        end else begin
                            state_next = WR_DROP;
                        end
                    end else if (in_last && in_user) begin
                        // Bad frame marked on its last beat
                        wr.rollback = 1'b1;
                        bad_next    = 1'b1;
                        state_next  = WR_IDLE;
                    end else if (in_last) begin
                        wr.wr_en   = 1'b1;
                        wr.commit  = 1'b1;
                        good_next  = 1'b1;
                        state_next = WR_IDLE;
                    end else begin
                        wr.wr_en   = 1'b1;
                        state_next = WR_STORE;
                    end
                end
                WR_DROP: begin
                    if (in_last) begin
                        overflow_next = 1'b1;
                        state_next    = WR_IDLE;
                    end
                end
                default: state_next = WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= WR_IDLE;
            overflow   <= 1'b0;
            bad_frame  <= 1'b0;
            good_frame <= 1'b0;
        end else begin
            state      <= state_next;
            overflow   <= overflow_next;
            bad_frame  <= bad_next;
            good_frame <= good_next;
        end
    end

endmodule

/* rtl/fifo_wr_if.sv */
`timescale 1ns/100ps

interface fifo_wr_if
    import rx_fifo_pkg::*;
#(
    parameter int ADDR_W = 4
) ();

    // Beat write strobe and payload
    logic              wr_en;
    beat_data_t        wr_data;
    beat_keep_t        wr_keep;
    logic              wr_last;

    // Frame boundary decisions, never both in one cycle
    logic              commit;
    logic              rollback;

    // Slot for the current beat and free-space flag
    logic [ADDR_W-1:0] wr_addr;
    logic              room;

    modport fsm (
        output wr_en, wr_data, wr_keep, wr_last, commit, rollback,
        input  room
    );

    modport ptr (
        input  wr_en, commit, rollback,
        output wr_addr, room
    );

    modport buff (
        input  wr_en, wr_addr, wr_data, wr_keep, wr_last
    );

endinterface

/* rtl/rx_fifo_pkg.sv */
package rx_fifo_pkg;

    // Beat geometry of the MAC-side stream
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // One beat of frame data
    typedef logic [DATA_W-1:0] beat_data_t;

    // Byte enables of a beat, one bit per data byte
    typedef logic [KEEP_W-1:0] beat_keep_t;

    // Per-frame write decision
    //   WR_IDLE   waiting for the first beat of a frame
    //   WR_STORE  frame beats are going into storage
    //   WR_DROP   frame ran out of room, swallow beats until last
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_STORE,
        WR_DROP
    } wr_state_t;

endpackage
